/* Bender.yml */
package:
  name: y86_fetch

sources:
  - hdl/y86_fetch_pkg.sv
  - hdl/instr_mem.sv
  - hdl/fetch_decode.sv
  - hdl/pc_predict.sv
  - hdl/fetch_credit_out.sv
  - hdl/y86_fetch_top.sv
  - target: test
    files:
      - verif/tb_y86_fetch.sv

/* hdl/fetch_credit_out.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_credit_out #(
  parameter int CREDITS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fire,
  input  y86_fetch_pkg::fetch_pkt_t pkt_in,
  input  logic                     credit_return,
  output logic                     can_fetch,
  output logic                     pkt_valid,
  output y86_fetch_pkg::fetch_pkt_t pkt
);

  import y86_fetch_pkg::*;

  localparam int CW = $clog2(CREDITS + 1);

  // free slots in the downstream buffer
  logic [CW-1:0] credits;
  logic          full;

  assign full = (credits == CW'(CREDITS));

  // send only while a slot is known free
  assign can_fetch = (credits != '0);

  // valid is a one-cycle pulse per packet
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pkt_valid <= 1'b0;
    end
    else
    begin
      pkt_valid <= fire;
    end
  end

  // take one on send, give one back on return
  // both in the same cycle cancel out
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credits <= CW'(CREDITS);
    end
    else
    begin
      case ({fire, credit_return})
        2'b10:
        begin
          credits <= credits - 1'b1;
        end
        2'b01:
        begin
          // spurious return past the buffer depth is ignored
          if (!full)
          begin
            credits <= credits + 1'b1;
          end
        end
        default:
        begin
          credits <= credits;
        end
      endcase
    end
  end

  // packet payload, held between sends
  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      pkt <= pkt_in;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode (
  input  logic [63:0]               pc,
  input  y86_fetch_pkg::instr_word_u word,
  input  logic [3:0]                avail,
  output y86_fetch_pkg::fetch_pkt_t  pkt
);

  import y86_fetch_pkg::*;

  icode_e     icode;
  logic [3:0] len;
  logic       illegal;

  // icode sits in the same place in both views
  assign icode = word.reg_form.icode;

  // C..F
  assign illegal = (icode > POP);

  always_comb
  begin
    pkt       = '0;
    pkt.icode = icode;
    pkt.pc    = pc;
    pkt.ra    = REG_NONE;
    pkt.rb    = REG_NONE;
    len       = 4'd1;

    case (icode)
      // single byte
      HALT, NOP, RET:
      begin
        pkt.ifun = word.reg_form.ifun;
        len      = 4'd1;
      end

      // opcode + register byte
      RRMOV, OPQ, PUSH, POP:
      begin
        pkt.ifun = word.reg_form.ifun;
        pkt.ra   = word.reg_form.ra;
        pkt.rb   = word.reg_form.rb;
        len      = 4'd2;
      end

      // opcode + register byte + constant
      IRMOV, RMMOV, MRMOV:
      begin
        pkt.ifun = word.reg_form.ifun;
        pkt.ra   = word.reg_form.ra;
        pkt.rb   = word.reg_form.rb;
        pkt.valc = word.reg_form.valc;
        len      = 4'd10;
      end

      // opcode + destination, no register byte
      JXX, CALL:
      begin
        pkt.ifun = word.dest_form.ifun;
        pkt.valc = word.dest_form.dest;
        len      = 4'd9;
      end

      // illegal icode
      // fields zeroed, length one byte
      default:
      begin
        pkt.ifun = 4'h0;
        pkt.ra   = 4'h0;
        pkt.rb   = 4'h0;
        pkt.valc = '0;
        len      = 4'd1;
      end
    endcase

    pkt.valp = pc + 64'(len);

    // status, address error first
    if ((avail == 4'd0) || (avail < len))
    begin
      pkt.stat = ADR;
    end
    else if (illegal)
    begin
      pkt.stat = INS;
    end
    else if (icode == HALT)
    begin
      pkt.stat = HLT;
    end
    else
    begin
      pkt.stat = AOK;
    end
  end

endmodule

`default_nettype wire

/* hdl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
  parameter int IMEM_BYTES = 1024
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_en,
  input  logic [63:0]              load_addr,
  input  logic [7:0]               load_byte,
  input  logic [63:0]              pc,
  output y86_fetch_pkg::instr_word_u word,
  output logic [3:0]               avail
);

  import y86_fetch_pkg::*;

  localparam int AW = $clog2(IMEM_BYTES);

  logic [7:0]           mem [IMEM_BYTES];
  logic [63:0]          room;
  logic [WORD_BITS-1:0] win;

  // byte write port
  // loads seen during reset are dropped
  always_ff @(posedge clk)
  begin
    if (rst_n && load_en && (load_addr < 64'(IMEM_BYTES)))
    begin
      mem[load_addr[AW-1:0]] <= load_byte;
    end
  end

  // bytes left from pc to end of memory
  assign room = (pc < 64'(IMEM_BYTES)) ? (64'(IMEM_BYTES) - pc) : '0;

  // saturates at one full instruction
  assign avail = (room >= 64'(INSTR_BYTES)) ? 4'(INSTR_BYTES) : room[3:0];

  // ten-byte read window, first byte most significant
  // out of range bytes read as zero
  always_comb
  begin
    win = '0;
    for (int i = 0; i < INSTR_BYTES; i++)
    begin
      // pc + i stays below IMEM_BYTES here, so the index cannot wrap
      if (64'(i) < room)
      begin
        win[WORD_BITS-1-8*i -: 8] = mem[pc[AW-1:0] + AW'(i)];
      end
    end
  end

  assign word = win;

endmodule

`default_nettype wire

/* hdl/pc_predict.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_predict (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic [63:0]              start_pc,
  input  logic                     redirect_valid,
  input  logic [63:0]              redirect_pc,
  input  y86_fetch_pkg::fetch_pkt_t pkt,
  input  logic                     can_fetch,
  output logic [63:0]              pc,
  output logic                     fire
);

  import y86_fetch_pkg::*;

  logic        halted;
  logic        stalled;
  logic        taken;
  logic [63:0] pred_pc;

  // jumps and calls predicted taken
  assign taken = (pkt.icode == JXX) || (pkt.icode == CALL);

  // everything else falls through to valp
  assign pred_pc = taken ? pkt.valc : pkt.valp;

  // one instruction per cycle while credit lasts
  assign fire = can_fetch && !halted && !stalled;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc      <= '0;
      halted  <= 1'b1;
      stalled <= 1'b0;
    end
    else
    begin
      // pc source, start over redirect over prediction
      if (start)
      begin
        pc <= start_pc;
      end
      else if (redirect_valid)
      begin
        pc <= redirect_pc;
      end
      else if (fire)
      begin
        pc <= pred_pc;
      end

      // halt on any bad status, only start restarts
      if (start)
      begin
        halted <= 1'b0;
      end
      else if (fire && (pkt.stat != AOK))
      begin
        halted <= 1'b1;
      end

      // ret waits for the return address from downstream
      if (start || redirect_valid)
      begin
        stalled <= 1'b0;
      end
      else if (fire && (pkt.icode == RET))
      begin
        stalled <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/y86_fetch_pkg.sv */
`default_nettype none

package y86_fetch_pkg;

  // longest y86 instruction, opcode byte + reg byte + 8-byte constant
  localparam int INSTR_BYTES = 10;
  localparam int WORD_BITS = INSTR_BYTES * 8;

  // register code meaning no register
  localparam logic [3:0] REG_NONE = 4'hF;

  // icode, high nibble of the first byte
  // C..F are not defined and decode as illegal
  typedef enum logic [3:0] {
    HALT  = 4'h0,
    NOP   = 4'h1,
    RRMOV = 4'h2,
    IRMOV = 4'h3,
    RMMOV = 4'h4,
    MRMOV = 4'h5,
    OPQ   = 4'h6,
    JXX   = 4'h7,
    CALL  = 4'h8,
    RET   = 4'h9,
    PUSH  = 4'hA,
    POP   = 4'hB
  } icode_e;

  // fetch status
  typedef enum logic [1:0] {
    AOK = 2'd0,
    HLT = 2'd1,
    ADR = 2'd2,
    INS = 2'd3
  } stat_e;

  // layout with register byte, rrmov/irmov/rmmov/mrmov/opq/push/pop
  typedef struct packed {
    icode_e      icode;
    logic [3:0]  ifun;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [63:0] valc;
  } reg_form_t;

  // layout without register byte, jxx and call
  // the destination follows the opcode byte directly
  typedef struct packed {
    icode_e      icode;
    logic [3:0]  ifun;
    logic [63:0] dest;
    logic [7:0]  tail;
  } dest_form_t;

  // ten bytes at pc, first byte in the top bits
  typedef union packed {
    reg_form_t  reg_form;
    dest_form_t dest_form;
  } instr_word_u;

  // one fetched instruction as sent downstream, 210 bits
  typedef struct packed {
    icode_e      icode;
    logic [3:0]  ifun;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [63:0] valc;
    logic [63:0] valp;
    logic [63:0] pc;
    stat_e       stat;
  } fetch_pkt_t;

endpackage

`default_nettype wire

/* hdl/y86_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module y86_fetch_top #(
  parameter int IMEM_BYTES = 1024,
  parameter int CREDITS = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_en,
  input  logic [63:0]              load_addr,
  input  logic [7:0]               load_byte,
  input  logic                     start,
  input  logic [63:0]              start_pc,
  input  logic                     redirect_valid,
  input  logic [63:0]              redirect_pc,
  output logic                     pkt_valid,
  output y86_fetch_pkg::fetch_pkt_t pkt,
  input  logic                     credit_return
);

  import y86_fetch_pkg::*;

  logic [63:0] pc;
  instr_word_u word;
  logic [3:0]  avail;
  fetch_pkt_t  dec_pkt;
  logic        can_fetch;
  logic        fire;

  // instruction bytes at pc
  instr_mem #(
    .IMEM_BYTES (IMEM_BYTES)
  ) instr_mem_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_byte (load_byte),
    .pc        (pc),
    .word      (word),
    .avail     (avail)
  );

  // fields, valp and status
  fetch_decode fetch_decode_inst (
    .pc    (pc),
    .word  (word),
    .avail (avail),
    .pkt   (dec_pkt)
  );

  // next pc and fetch enable
  pc_predict pc_predict_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .start_pc       (start_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pkt            (dec_pkt),
    .can_fetch      (can_fetch),
    .pc             (pc),
    .fire           (fire)
  );

  // registered packet out, credit flow control
  fetch_credit_out #(
    .CREDITS (CREDITS)
  ) fetch_credit_out_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fire          (fire),
    .pkt_in        (dec_pkt),
    .credit_return (credit_return),
    .can_fetch     (can_fetch),
    .pkt_valid     (pkt_valid),
    .pkt           (pkt)
  );

endmodule

`default_nettype wire

/* verif/tb_y86_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_y86_fetch;

  import y86_fetch_pkg::*;

  localparam int MEM = 128;
  localparam int NCRED = 4;

  logic        clk;
  logic        rst_n;
  logic        load_en;
  logic        start;
  logic        redirect_valid;
  logic        credit_return;
  logic        pkt_valid;
  logic [63:0] load_addr;
  logic [63:0] start_pc;
  logic [63:0] redirect_pc;
  logic [7:0]  load_byte;
  fetch_pkt_t  pkt;

  // tb copy of memory contents
  logic [7:0] img [MEM];
  // program bytes staged before loading
  logic [7:0] prog [$];
  fetch_pkt_t got_q [$];
  fetch_pkt_t exp_q [$];
  fetch_pkt_t last_pkt;
  int errors = 0;
  int checks = 0;
  int timeouts = 0;
  // credits owed to the DUT
  int owed = 0;
  // 0 auto return, 1 hold, 2 random return
  int credit_mode = 0;

  y86_fetch_top #(
    .IMEM_BYTES (MEM),
    .CREDITS    (NCRED)
  ) y86_fetch_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_en        (load_en),
    .load_addr      (load_addr),
    .load_byte      (load_byte),
    .start          (start),
    .start_pc       (start_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pkt_valid      (pkt_valid),
    .pkt            (pkt),
    .credit_return  (credit_return)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // packets sampled mid-cycle away from the edge
  always @(negedge clk)
  begin
    if (rst_n && pkt_valid)
    begin
      got_q.push_back(pkt);
      owed++;
    end
  end

  // consumer side, one credit back per freed packet
  always @(posedge clk)
  begin
    #2;
    if (owed > 0 && (credit_mode == 0 || (credit_mode == 2 && ($urandom % 3) == 0)))
    begin
      credit_return = 1'b1;
      owed--;
    end
    else
    begin
      credit_return = 1'b0;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic emit(input logic [7:0] b);
    prog.push_back(b);
  endtask

  // constants go first byte most significant
  task automatic emit_q(input logic [63:0] v);
    for (int i = 7; i >= 0; i--)
    begin
      emit(v[8*i +: 8]);
    end
  endtask

  task automatic load_program(input int base);
    for (int i = 0; i < prog.size(); i++)
    begin
      load_en = 1'b1;
      load_addr = 64'(base + i);
      load_byte = prog[i];
      img[base + i] = prog[i];
      @(posedge clk);
      #2;
    end
    load_en = 1'b0;
    prog.delete();
  endtask

  task automatic start_fetch(input logic [63:0] pc);
    start = 1'b1;
    start_pc = pc;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic redirect(input logic [63:0] pc);
    redirect_valid = 1'b1;
    redirect_pc = pc;
    @(posedge clk);
    #2;
    redirect_valid = 1'b0;
  endtask

  // reference decode of the bytes at pc
  function automatic fetch_pkt_t ref_pkt(input logic [63:0] pc);
    fetch_pkt_t p;
    logic [7:0] b [10];
    int len;
    int avl;
    int s;
    for (int i = 0; i < 10; i++)
    begin
      b[i] = (pc + 64'(i) < 64'(MEM)) ? img[int'(pc) + i] : 8'h00;
    end
    avl = (pc >= 64'(MEM)) ? 0 : ((MEM - int'(pc) > 10) ? 10 : MEM - int'(pc));
    p = '0;
    p.pc = pc;
    p.icode = icode_e'(b[0][7:4]);
    p.ifun = b[0][3:0];
    p.ra = REG_NONE;
    p.rb = REG_NONE;
    len = 1;
    s = 0;
    case (b[0][7:4])
      4'h0, 4'h1, 4'h9: len = 1;
      4'h2, 4'h6, 4'hA, 4'hB: len = 2;
      4'h3, 4'h4, 4'h5: len = 10;
      4'h7, 4'h8: len = 9;
      default: len = 1;
    endcase
    if (len >= 2 && len != 9)
    begin
      p.ra = b[1][7:4];
      p.rb = b[1][3:0];
    end
    // constant after the register byte or right after opcode
    s = (len == 10) ? 2 : 1;
    if (len >= 9)
    begin
      for (int k = 0; k < 8; k++)
      begin
        p.valc = {p.valc[55:0], b[s + k]};
      end
    end
    if (b[0][7:4] >= 4'hC)
    begin
      p.ifun = 4'h0;
      p.ra = 4'h0;
      p.rb = 4'h0;
    end
    p.valp = pc + 64'(len);
    if (avl == 0 || avl < len)
    begin
      p.stat = ADR;
    end
    else if (b[0][7:4] >= 4'hC)
    begin
      p.stat = INS;
    end
    else if (b[0][7:4] == 4'h0)
    begin
      p.stat = HLT;
    end
    else
    begin
      p.stat = AOK;
    end
    return p;
  endfunction

  // walk the predicted path until halt, error or ret
  task automatic build_expect(input logic [63:0] pc0);
    fetch_pkt_t p;
    logic [63:0] pc;
    bit more;
    pc = pc0;
    more = 1'b1;
    while (more && exp_q.size() < 64)
    begin
      p = ref_pkt(pc);
      exp_q.push_back(p);
      pc = (p.icode == JXX || p.icode == CALL) ? p.valc : p.valp;
      more = (p.stat == AOK) && (p.icode != RET);
    end
  endtask

  task automatic expect_pkt();
    fetch_pkt_t g;
    fetch_pkt_t e;
    int t;
    e = exp_q.pop_front();
    t = 0;
    while (got_q.size() == 0 && t < 200)
    begin
      @(posedge clk);
      #2;
      t++;
    end
    if (got_q.size() == 0)
    begin
      timeouts++;
      $display("no packet arrived within 200 cycles, expected one for pc %h", e.pc);
    end
    else
    begin
      g = got_q.pop_front();
      last_pkt = g;
      check("pkt.pc", g.pc, e.pc);
      check("pkt.icode", 64'(g.icode), 64'(e.icode));
      check("pkt.ifun", 64'(g.ifun), 64'(e.ifun));
      check("pkt.ra", 64'(g.ra), 64'(e.ra));
      check("pkt.rb", 64'(g.rb), 64'(e.rb));
      check("pkt.valc", g.valc, e.valc);
      check("pkt.valp", g.valp, e.valp);
      check("pkt.stat", 64'(g.stat), 64'(e.stat));
    end
  endtask

  task automatic run_expect();
    while (exp_q.size() > 0)
    begin
      expect_pkt();
    end
  endtask

  // no packet may show up for n cycles
  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
    if (got_q.size() != 0)
    begin
      errors++;
      $display("unexpected packet while fetch should be idle, pc %h", got_q[0].pc);
      got_q.delete();
    end
  endtask

  task automatic field_test();
    emit(8'h10);
    emit(8'h20);
    emit(8'h12);
    emit(8'h30);
    emit(8'hF3);
    emit_q(64'h0123_4567_89AB_CDEF);
    emit(8'h40);
    emit(8'h12);
    emit_q(64'h10);
    emit(8'h50);
    emit(8'h34);
    emit_q(64'h18);
    emit(8'h61);
    emit(8'h23);
    // jxx and call targets point at the next instruction
    emit(8'h73);
    emit_q(64'(prog.size() + 8));
    emit(8'h80);
    emit_q(64'(prog.size() + 8));
    emit(8'hA0);
    emit(8'h3F);
    emit(8'hB0);
    emit(8'h4F);
    emit(8'h00);
    load_program(0);
    build_expect(64'h0);
    start_fetch(64'h0);
    run_expect();
    expect_quiet(12);
  endtask

  task automatic predict_test();
    emit(8'h70);
    emit_q(64'h40);
    load_program(0);
    emit(8'h80);
    emit_q(64'h60);
    load_program(64);
    emit(8'h00);
    load_program(96);
    build_expect(64'h0);
    start_fetch(64'h0);
    expect_pkt();
    expect_pkt();
    check("pc_after_jxx", last_pkt.pc, 64'h40);
    expect_pkt();
    check("pc_after_call", last_pkt.pc, 64'h60);
    expect_quiet(8);
  endtask

  task automatic ret_test();
    emit(8'h10);
    emit(8'h90);
    load_program(0);
    emit(8'h10);
    emit(8'h00);
    load_program(48);
    build_expect(64'h0);
    start_fetch(64'h0);
    run_expect();
    // stalled on ret until the return address arrives
    expect_quiet(12);
    build_expect(64'd48);
    redirect(64'd48);
    run_expect();
    expect_quiet(8);
  endtask

  task automatic error_test();
    emit(8'hC0);
    load_program(0);
    build_expect(64'h0);
    start_fetch(64'h0);
    run_expect();
    // redirect must not wake a halted fetch
    redirect(64'h0);
    expect_quiet(10);
    // irmov with only six bytes left before the end
    emit(8'h30);
    emit(8'hF1);
    emit(8'h00);
    emit(8'h00);
    emit(8'h00);
    emit(8'h00);
    load_program(MEM - 6);
    build_expect(64'(MEM - 6));
    start_fetch(64'(MEM - 6));
    run_expect();
    expect_quiet(10);
  endtask

  task automatic credit_test();
    int t;
    t = 0;
    while (owed > 0 && t < 50)
    begin
      @(posedge clk);
      #2;
      t++;
    end
    if (owed > 0)
    begin
      timeouts++;
      $display("credits still owed after 50 cycles");
    end
    repeat (12) emit(8'h10);
    emit(8'h00);
    load_program(0);
    build_expect(64'h0);
    credit_mode = 1;
    start_fetch(64'h0);
    repeat (20)
    begin
      @(posedge clk);
      #2;
    end
    check("packets_without_credit", 64'(got_q.size()), 64'(NCRED));
    credit_mode = 2;
    run_expect();
    expect_quiet(10);
    credit_mode = 0;
  endtask

  initial
  begin
    rst_n = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_byte = '0;
    start = 1'b0;
    start_pc = '0;
    redirect_valid = 1'b0;
    redirect_pc = '0;
    credit_return = 1'b0;
    void'($urandom(57758));
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // whole memory gets a known pattern first
    for (int a = 0; a < MEM; a++)
    begin
      emit(8'(a * 37 + (a >> 3)) ^ 8'h5A);
    end
    load_program(0);
    expect_quiet(4);
    field_test();
    predict_test();
    ret_test();
    error_test();
    credit_test();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* y86_fetch.f */
hdl/y86_fetch_pkg.sv
hdl/instr_mem.sv
hdl/fetch_decode.sv
hdl/pc_predict.sv
hdl/fetch_credit_out.sv
hdl/y86_fetch_top.sv
verif/tb_y86_fetch.sv
